/* Bender.yml */
package:
  name: obi_data_integ

sources:
  - obi_integ_pkg.sv
  - obi_data_if.sv
  - obi_rchk_check.sv
  - obi_data_adapter.sv
  - obi_outstanding_cnt.sv
  - obi_integ_fsm.sv
  - obi_data_integ_top.sv
  - target: test
    files:
      - obi_data_integ_assertions.sv
      - tb_obi_data_integ_top.sv

/* obi_data_adapter.sv */
/*
 * OBI data adapter
 * Drives the A channel with achk and reqpar, tracks per-transaction
 * attributes and checks gnt, rvalid and rchk integrity on the way back
 */

`timescale 1ns/1ps

module obi_data_adapter (
  input  logic                 clk,
  input  logic                 rst_n,
  // Gated transaction request
  input  logic                 issue_valid_i,
  output logic                 issue_ready_o,
  input  obi_integ_pkg::addr_t trans_addr_i,
  input  logic                 trans_we_i,
  input  obi_integ_pkg::be_t   trans_be_i,
  input  obi_integ_pkg::data_t trans_wdata_i,
  input  logic                 trans_integrity_i,
  // Control and bus occupancy
  input  logic                 integrity_en_i,
  input  obi_integ_pkg::cnt_t  bus_cnt_i,
  // Transaction response, consumer always ready
  output logic                 resp_valid_o,
  output obi_integ_pkg::data_t resp_rdata_o,
  output logic                 resp_err_o,
  output logic                 resp_integrity_o,
  output logic                 resp_integrity_err_o,
  output logic                 integrity_err_o,
  obi_data_if.manager          bus
);

  localparam int unsigned MAX = obi_integ_pkg::MAX_OUTSTANDING;

  // One bit deeper than the count, index 0 stays zero
  logic [MAX:0] fifo_integ_q;
  logic [MAX:0] fifo_gnterr_q;
  logic [MAX:0] fifo_store_q;

  logic       gntpar_err;
  logic       gntpar_err_q;
  logic       gntpar_err_resp;
  logic       rvalidpar_err;
  logic       resp_is_store;
  logic [1:0] rchk_en;
  logic       rchk_err;

  //////////////////////////////
  // A channel
  //////////////////////////////

  // Source holds trans_* stable until the grant
  assign bus.req    = issue_valid_i;
  assign bus.reqpar = ~issue_valid_i;
  assign bus.addr   = trans_addr_i;
  assign bus.we     = trans_we_i;
  assign bus.be     = trans_be_i;
  assign bus.wdata  = trans_wdata_i;

  // Bits 7, 6 and 4 cover atop, dbg, prot and memtype, all zero here
  assign bus.achk = {
    ^trans_wdata_i[31:24],
    ^trans_wdata_i[23:16],
    ^trans_wdata_i[15:8],
    ^trans_wdata_i[7:0],
    1'b0,
    1'b1,
    ~^{trans_be_i, trans_we_i},
    1'b1,
    ^trans_addr_i[31:24],
    ^trans_addr_i[23:16],
    ^trans_addr_i[15:8],
    ^trans_addr_i[7:0]
  };

  assign issue_ready_o = bus.gnt;

  // Grant parity, error when gntpar equals gnt
  assign gntpar_err = (bus.gnt == bus.gntpar);

  // Sticky over waited grants, cleared when the address phase ends
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gntpar_err_q <= 1'b0;
    end else if (bus.req) begin
      if (bus.gnt) begin
        gntpar_err_q <= 1'b0;
      end else begin
        gntpar_err_q <= gntpar_err_q || gntpar_err;
      end
    end
  end

  //////////////////////////////
  // Per-transaction FIFO
  //////////////////////////////

  // Newest entry enters at index 1, older ones move up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_integ_q  <= '0;
      fifo_gnterr_q <= '0;
      fifo_store_q  <= '0;
    end else if (bus.req && bus.gnt) begin
      fifo_integ_q  <= {fifo_integ_q[MAX-1:1], trans_integrity_i, 1'b0};
      fifo_gnterr_q <= {fifo_gnterr_q[MAX-1:1], gntpar_err || gntpar_err_q, 1'b0};
      fifo_store_q  <= {fifo_store_q[MAX-1:1], trans_we_i, 1'b0};
    end
  end

  //////////////////////////////
  // R channel
  //////////////////////////////

  assign resp_valid_o = bus.rvalid;
  assign resp_rdata_o = bus.rdata;
  assign resp_err_o   = bus.err;

  // Oldest outstanding entry sits at the current count
  assign resp_integrity_o = fifo_integ_q[bus_cnt_i];
  assign resp_is_store    = fifo_store_q[bus_cnt_i];
  assign gntpar_err_resp  = bus.rvalid && fifo_gnterr_q[bus_cnt_i];

  assign rvalidpar_err = (bus.rvalid == bus.rvalidpar);

  // Data groups only for loads, err group for every response
  assign rchk_en[0] = bus.rvalid && integrity_en_i && !resp_is_store;
  assign rchk_en[1] = bus.rvalid && integrity_en_i;

  obi_rchk_check rchk_check_i (
    .rdata_i  (bus.rdata),
    .err_i    (bus.err),
    .rchk_i   (bus.rchk),
    .enable_i (rchk_en),
    .err_o    (rchk_err)
  );

  assign resp_integrity_err_o = rvalidpar_err || gntpar_err_resp || rchk_err;

  // Immediate gnt parity errors are reported without waiting for the response
  assign integrity_err_o = resp_integrity_err_o || gntpar_err;

endmodule

/* obi_data_if.sv */
/*
 * OBI data bus interface
 * A channel with achk and reqpar, R channel with rchk and rvalidpar
 */

`timescale 1ns/1ps

interface obi_data_if;

  //////////////////////////////
  // A channel
  //////////////////////////////

  logic                 req;
  logic                 reqpar;
  logic                 gnt;
  logic                 gntpar;
  obi_integ_pkg::addr_t addr;
  logic                 we;
  obi_integ_pkg::be_t   be;
  obi_integ_pkg::data_t wdata;
  obi_integ_pkg::achk_t achk;

  //////////////////////////////
  // R channel
  //////////////////////////////

  logic                 rvalid;
  logic                 rvalidpar;
  obi_integ_pkg::data_t rdata;
  logic                 err;
  obi_integ_pkg::rchk_t rchk;

  // Adapter side, drives the request
  modport manager (
    output req, reqpar, addr, we, be, wdata, achk,
    input  gnt, gntpar, rvalid, rvalidpar, rdata, err, rchk
  );

  // Bus side, answers grants and responses
  modport subordinate (
    input  req, reqpar, addr, we, be, wdata, achk,
    output gnt, gntpar, rvalid, rvalidpar, rdata, err, rchk
  );

  // Passive observer
  modport monitor (
    input req, reqpar, gnt, gntpar, addr, we, be, wdata, achk,
    input rvalid, rvalidpar, rdata, err, rchk
  );

endinterface

/* obi_data_integ.f */
obi_integ_pkg.sv
obi_data_if.sv
obi_rchk_check.sv
obi_data_adapter.sv
obi_outstanding_cnt.sv
obi_integ_fsm.sv
obi_data_integ_top.sv
obi_data_integ_assertions.sv
tb_obi_data_integ_top.sv

/* obi_data_integ_assertions.sv */
/*
 * OBI data integrity assertions
 * Request parity, request stability, outstanding limit and sticky alert
 */

`timescale 1ns/1ps

module obi_data_integ_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req_i,
  input logic                 reqpar_i,
  input logic                 gnt_i,
  input obi_integ_pkg::addr_t addr_i,
  input logic                 we_i,
  input obi_integ_pkg::be_t   be_i,
  input obi_integ_pkg::data_t wdata_i,
  input obi_integ_pkg::cnt_t  bus_cnt_i,
  input logic                 alert_i
);

  // Count of failed assertions
  int unsigned fails;

  // Request parity is always the inverse of req
  reqpar_inv: assert property (@(posedge clk) disable iff (!rst_n) reqpar_i == !req_i)
    else begin
      fails++;
      $error("reqpar is not the inverse of req");
    end

  // Fields hold while a request waits for its grant
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) ##1 req_i |-> $stable(addr_i) && $stable(we_i) &&
                                    $stable(be_i) && $stable(wdata_i))
    else begin
      fails++;
      $error("request fields changed before the grant");
    end

  // No address phase may be accepted once the limit is reached
  cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_cnt_i <= obi_integ_pkg::MAX_OUTSTANDING) &&
    !((bus_cnt_i == obi_integ_pkg::MAX_OUTSTANDING) && req_i && gnt_i))
    else begin
      fails++;
      $error("outstanding count pushed above the limit");
    end

  // Major alert is sticky until reset
  alert_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(alert_i))
    else begin
      fails++;
      $error("major alert fell without reset");
    end

endmodule

bind obi_data_integ_top obi_data_integ_assertions integ_assertions_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_i     (obi_req_o),
  .reqpar_i  (obi_reqpar_o),
  .gnt_i     (obi_gnt_i),
  .addr_i    (obi_addr_o),
  .we_i      (obi_we_o),
  .be_i      (obi_be_o),
  .wdata_i   (obi_wdata_o),
  .bus_cnt_i (bus_cnt),
  .alert_i   (alert_major_o)
);

/* obi_data_integ_top.sv */
/*
 * OBI data integrity top level
 * Adapter, outstanding counter and integrity FSM on plain bus ports
 */

`timescale 1ns/1ps

module obi_data_integ_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // Transaction request
  input  logic                 trans_valid_i,
  output logic                 trans_ready_o,
  input  obi_integ_pkg::addr_t trans_addr_i,
  input  logic                 trans_we_i,
  input  obi_integ_pkg::be_t   trans_be_i,
  input  obi_integ_pkg::data_t trans_wdata_i,
  input  logic                 trans_integrity_i,
  // Transaction response
  output logic                 resp_valid_o,
  output obi_integ_pkg::data_t resp_rdata_o,
  output logic                 resp_err_o,
  output logic                 resp_integrity_o,
  output logic                 resp_integrity_err_o,
  // Control and status
  input  logic                 integrity_en_i,
  output logic                 alert_major_o,
  output logic                 halted_o,
  // OBI A channel
  output logic                 obi_req_o,
  output logic                 obi_reqpar_o,
  input  logic                 obi_gnt_i,
  input  logic                 obi_gntpar_i,
  output obi_integ_pkg::addr_t obi_addr_o,
  output logic                 obi_we_o,
  output obi_integ_pkg::be_t   obi_be_o,
  output obi_integ_pkg::data_t obi_wdata_o,
  output obi_integ_pkg::achk_t obi_achk_o,
  // OBI R channel
  input  logic                 obi_rvalid_i,
  input  logic                 obi_rvalidpar_i,
  input  obi_integ_pkg::data_t obi_rdata_i,
  input  logic                 obi_err_i,
  input  obi_integ_pkg::rchk_t obi_rchk_i
);

  logic                issue_valid;
  logic                issue_ready;
  logic                integrity_err;
  logic                full;
  obi_integ_pkg::cnt_t bus_cnt;

  obi_data_if bus_if ();

  //////////////////////////////
  // Bus side of the interface
  //////////////////////////////

  assign obi_req_o    = bus_if.req;
  assign obi_reqpar_o = bus_if.reqpar;
  assign obi_addr_o   = bus_if.addr;
  assign obi_we_o     = bus_if.we;
  assign obi_be_o     = bus_if.be;
  assign obi_wdata_o  = bus_if.wdata;
  assign obi_achk_o   = bus_if.achk;

  assign bus_if.gnt       = obi_gnt_i;
  assign bus_if.gntpar    = obi_gntpar_i;
  assign bus_if.rvalid    = obi_rvalid_i;
  assign bus_if.rvalidpar = obi_rvalidpar_i;
  assign bus_if.rdata     = obi_rdata_i;
  assign bus_if.err       = obi_err_i;
  assign bus_if.rchk      = obi_rchk_i;

  obi_integ_fsm integ_fsm_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .trans_valid_i   (trans_valid_i),
    .trans_ready_o   (trans_ready_o),
    .issue_valid_o   (issue_valid),
    .issue_ready_i   (issue_ready),
    .full_i          (full),
    .bus_cnt_i       (bus_cnt),
    .resp_valid_i    (resp_valid_o),
    .integrity_err_i (integrity_err),
    .alert_major_o   (alert_major_o),
    .halted_o        (halted_o)
  );

  obi_data_adapter data_adapter_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .issue_valid_i        (issue_valid),
    .issue_ready_o        (issue_ready),
    .trans_addr_i         (trans_addr_i),
    .trans_we_i           (trans_we_i),
    .trans_be_i           (trans_be_i),
    .trans_wdata_i        (trans_wdata_i),
    .trans_integrity_i    (trans_integrity_i),
    .integrity_en_i       (integrity_en_i),
    .bus_cnt_i            (bus_cnt),
    .resp_valid_o         (resp_valid_o),
    .resp_rdata_o         (resp_rdata_o),
    .resp_err_o           (resp_err_o),
    .resp_integrity_o     (resp_integrity_o),
    .resp_integrity_err_o (resp_integrity_err_o),
    .integrity_err_o      (integrity_err),
    .bus                  (bus_if)
  );

  obi_outstanding_cnt outstanding_cnt_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus_if),
    .bus_cnt_o (bus_cnt),
    .full_o    (full)
  );

endmodule

/* obi_integ_fsm.sv */
/*
 * Integrity FSM
 * Gates new transactions, drains the bus after an integrity error, then halts
 */

`timescale 1ns/1ps

module obi_integ_fsm (
  input  logic                clk,
  input  logic                rst_n,
  // Transaction source side
  input  logic                trans_valid_i,
  output logic                trans_ready_o,
  // Adapter side
  output logic                issue_valid_o,
  input  logic                issue_ready_i,
  // Bus occupancy
  input  logic                full_i,
  input  obi_integ_pkg::cnt_t bus_cnt_i,
  // Response and error status
  input  logic                resp_valid_i,
  input  logic                integrity_err_i,
  output logic                alert_major_o,
  output logic                halted_o
);

  obi_integ_pkg::integ_state_e state_q;
  obi_integ_pkg::integ_state_e state_d;
  logic                        allow;
  logic                        bus_idle;

  // New traffic only while running and below the limit
  assign allow = (state_q == obi_integ_pkg::INTEG_RUN) && !full_i;

  assign issue_valid_o = trans_valid_i && allow;
  assign trans_ready_o = issue_ready_i && allow;

  // Nothing in flight and no response in this cycle
  assign bus_idle = (bus_cnt_i == '0) && !resp_valid_i;

  //////////////////////////////
  // State transitions
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      obi_integ_pkg::INTEG_RUN: begin
        if (integrity_err_i) begin
          state_d = obi_integ_pkg::INTEG_DRAIN;
        end
      end
      obi_integ_pkg::INTEG_DRAIN: begin
        if (bus_idle) begin
          state_d = obi_integ_pkg::INTEG_HALT;
        end
      end
      // Only reset leaves the halted state
      default: state_d = obi_integ_pkg::INTEG_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= obi_integ_pkg::INTEG_RUN;
      alert_major_o <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky major alert
      if (integrity_err_i) begin
        alert_major_o <= 1'b1;
      end
    end
  end

  assign halted_o = (state_q == obi_integ_pkg::INTEG_HALT);

endmodule

/* obi_integ_pkg.sv */
/*
 * OBI data integrity package
 * Bus widths, vector types, outstanding limit and integrity FSM states
 */

package obi_integ_pkg;

  // Bus field widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;
  localparam int unsigned ACHK_W = 12;
  localparam int unsigned RCHK_W = 5;

  // Most transactions allowed in flight
  localparam int unsigned MAX_OUTSTANDING = 2;
  // Count must reach MAX_OUTSTANDING itself
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [ACHK_W-1:0] achk_t;
  typedef logic [RCHK_W-1:0] rchk_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Integrity FSM
  // Run accepts traffic, drain waits for the bus to empty, halt is final
  typedef enum logic [1:0] {
    INTEG_RUN   = 2'd0,
    INTEG_DRAIN = 2'd1,
    INTEG_HALT  = 2'd2
  } integ_state_e;

endpackage

/* obi_outstanding_cnt.sv */
/*
 * Outstanding transaction counter
 * Counts granted but unanswered OBI transactions, flags the limit
 */

`timescale 1ns/1ps

module obi_outstanding_cnt (
  input  logic                clk,
  input  logic                rst_n,
  obi_data_if.monitor         bus,
  output obi_integ_pkg::cnt_t bus_cnt_o,
  output logic                full_o
);

  obi_integ_pkg::cnt_t cnt_q;
  logic                accept;

  // Address phase ends on req and gnt together
  assign accept = bus.req && bus.gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({accept, bus.rvalid})
        2'b10: begin
          // Saturate at the limit
          if (!full_o) begin
            cnt_q <= cnt_q + obi_integ_pkg::cnt_t'(1);
          end
        end
        2'b01: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - obi_integ_pkg::cnt_t'(1);
          end
        end
        // Both or neither, count unchanged
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign bus_cnt_o = cnt_q;
  assign full_o    = (cnt_q == obi_integ_pkg::cnt_t'(obi_integ_pkg::MAX_OUTSTANDING));

endmodule

/* obi_rchk_check.sv */
/*
 * Response checksum checker
 * Recomputes rchk from rdata and err, flags mismatches in enabled groups
 */

`timescale 1ns/1ps

module obi_rchk_check (
  input  obi_integ_pkg::data_t rdata_i,
  input  logic                 err_i,
  input  obi_integ_pkg::rchk_t rchk_i,
  // Bit 0 enables the rdata byte groups, bit 1 the err group
  input  logic [1:0]           enable_i,
  output logic                 err_o
);

  obi_integ_pkg::rchk_t rchk_exp;
  obi_integ_pkg::rchk_t mismatch;

  // Even parity per group
  assign rchk_exp = {
    ^err_i,
    ^rdata_i[31:24],
    ^rdata_i[23:16],
    ^rdata_i[15:8],
    ^rdata_i[7:0]
  };

  assign mismatch = rchk_exp ^ rchk_i;

  // Byte groups only matter for load data
  assign err_o = (enable_i[0] && (|mismatch[3:0])) ||
                 (enable_i[1] && mismatch[4]);

endmodule

/* tb_obi_data_integ_top.sv */
/*
 * Testbench for the OBI data integrity top level
 * Random traffic against a bus subordinate model with fault injection
 */

`timescale 1ns/1ps

module tb_obi_data_integ_top;

  logic clk;
  logic rst_n;
  logic trans_valid_i, trans_ready_o, trans_we_i, trans_integrity_i;
  logic [31:0] trans_addr_i, trans_wdata_i;
  logic [3:0] trans_be_i;
  logic resp_valid_o, resp_err_o, resp_integrity_o, resp_integrity_err_o;
  logic [31:0] resp_rdata_o;
  logic integrity_en_i, alert_major_o, halted_o;
  logic obi_req_o, obi_reqpar_o, obi_gnt_i, obi_gntpar_i, obi_we_o;
  logic [31:0] obi_addr_o, obi_wdata_o, obi_rdata_i;
  logic [3:0] obi_be_o;
  logic [11:0] obi_achk_o;
  logic obi_rvalid_i, obi_rvalidpar_i, obi_err_i;
  logic [4:0] obi_rchk_i;

  integer seed;
  int     errors;

  // Bus model state and reference queue of accepted transactions
  logic [31:0] mem [0:15];
  int unsigned q_at[$];
  bit          q_we[$];
  bit          q_integ[$];
  bit          q_gflt[$];
  logic [31:0] q_rdata[$];
  int unsigned cyc, last_at, gwait;
  bit          rsp_active, gflt_now;
  bit          cur_we, cur_integ, cur_err, cur_exp_err;
  logic [31:0] cur_rdata;

  // Fault knobs that each fire once
  bit          knob_gnt, knob_rvp, knob_flip_we;
  logic [4:0]  knob_flip;

  obi_data_integ_top obi_data_integ_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Request checksum as even parity per group
  function automatic logic [11:0] calc_achk(input logic [31:0] a, input logic we,
                                            input logic [3:0] be, input logic [31:0] wd);
    logic [11:0] c;
    c[11:8] = {^wd[31:24], ^wd[23:16], ^wd[15:8], ^wd[7:0]};
    c[7]    = 1'b0;
    c[6]    = 1'b1;
    c[5]    = ~(^{be, we});
    c[4]    = 1'b1;
    c[3:0]  = {^a[31:24], ^a[23:16], ^a[15:8], ^a[7:0]};
    return c;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////
  // Bus subordinate model
  //////////////////////////////

  always begin : bus_model
    int unsigned at;
    bit          gnt_nx, gflt_nx, rsp_nx, rvp_nx, gflt;
    logic [31:0] rd_nx, ld;
    logic        err_nx;
    logic [4:0]  rchk_nx, flip;
    int          idx;
    @(negedge clk);
    gnt_nx  = 1'b0;
    gflt_nx = 1'b0;
    rsp_nx  = 1'b0;
    rvp_nx  = 1'b0;
    rd_nx   = '0;
    err_nx  = 1'b0;
    rchk_nx = '0;
    if (!rst_n) begin
      q_at.delete();
      q_we.delete();
      q_integ.delete();
      q_gflt.delete();
      q_rdata.delete();
      cyc     = 0;
      last_at = 0;
      gwait   = 0;
    end else begin
      cyc++;
      // Halt only once every response has returned
      if (halted_o) begin
        check("halted_o with responses pending", 0, q_at.size() + int'(rsp_active));
      end
      // Response driven in this cycle
      if (rsp_active) begin
        check("resp_valid_o", 1, resp_valid_o);
        if (!cur_we) begin
          check("load rdata", cur_rdata, resp_rdata_o);
        end
        check("resp_err_o", cur_err, resp_err_o);
        check("resp_integrity_o", cur_integ, resp_integrity_o);
        check("resp_integrity_err_o", cur_exp_err, resp_integrity_err_o);
      end else begin
        check("resp_valid_o idle", 0, resp_valid_o);
      end
      // No new transfer while two are unanswered
      if (q_at.size() + int'(rsp_active) >= 2) begin
        check("trans_ready_o at limit", 0, trans_ready_o);
      end
      if (obi_req_o && obi_gnt_i) begin
        check("obi_addr_o", trans_addr_i, obi_addr_o);
        check("obi_we_o", trans_we_i, obi_we_o);
        check("obi_be_o", trans_be_i, obi_be_o);
        check("obi_wdata_o", trans_wdata_i, obi_wdata_o);
        check("obi_achk_o", calc_achk(trans_addr_i, trans_we_i, trans_be_i, trans_wdata_i),
              obi_achk_o);
        idx = trans_addr_i[5:2];
        ld  = mem[idx];
        if (trans_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (trans_be_i[b]) begin
              mem[idx][8*b +: 8] = trans_wdata_i[8*b +: 8];
            end
          end
        end
        // Responses in order one to four cycles after the grant
        at = cyc + 1 + rnd(4);
        if (at <= last_at) begin
          at = last_at + 1;
        end
        last_at = at;
        q_at.push_back(at);
        q_we.push_back(trans_we_i);
        q_integ.push_back(trans_integrity_i);
        q_gflt.push_back(gflt_now);
        q_rdata.push_back(ld);
        gwait = rnd(4);
      end else if (obi_req_o && !obi_gnt_i && gwait != 0) begin
        gwait--;
      end
      gnt_nx = (gwait == 0);
      // Bad gntpar on the cycle that ends a waited request
      if (knob_gnt && gnt_nx && obi_req_o && !obi_gnt_i) begin
        gflt_nx  = 1'b1;
        knob_gnt = 1'b0;
      end
      if (q_at.size() != 0 && q_at[0] == cyc + 1) begin
        rsp_nx = 1'b1;
        void'(q_at.pop_front());
        cur_we    = q_we.pop_front();
        cur_integ = q_integ.pop_front();
        gflt      = q_gflt.pop_front();
        ld        = q_rdata.pop_front();
        rd_nx     = cur_we ? 32'($random(seed)) : ld;
        err_nx    = (rnd(8) == 0);
        cur_rdata = rd_nx;
        cur_err   = err_nx;
        rchk_nx   = {err_nx, ^rd_nx[31:24], ^rd_nx[23:16], ^rd_nx[15:8], ^rd_nx[7:0]};
        flip      = '0;
        if (knob_flip != '0 && cur_we == knob_flip_we) begin
          flip      = knob_flip;
          knob_flip = '0;
        end
        rchk_nx  = rchk_nx ^ flip;
        rvp_nx   = knob_rvp;
        knob_rvp = 1'b0;
        // Data groups count for loads only and the err group always
        cur_exp_err = rvp_nx || gflt || (integrity_en_i && !cur_we && (|flip[3:0])) ||
                      (integrity_en_i && flip[4]);
      end
    end
    @(posedge clk);
    #1;
    obi_gnt_i       = gnt_nx;
    obi_gntpar_i    = gflt_nx ? gnt_nx : !gnt_nx;
    gflt_now        = gflt_nx;
    obi_rvalid_i    = rsp_nx;
    obi_rvalidpar_i = rvp_nx ? rsp_nx : !rsp_nx;
    obi_rdata_i     = rd_nx;
    obi_err_i       = err_nx;
    obi_rchk_i      = rchk_nx;
    rsp_active      = rsp_nx;
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic reset_dut();
    rst_n         = 1'b0;
    trans_valid_i = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("reset alert_major_o", 0, alert_major_o);
    check("reset halted_o", 0, halted_o);
    check("reset obi_req_o", 0, obi_req_o);
    check("reset resp_valid_o", 0, resp_valid_o);
    @(posedge clk);
    #1;
  endtask

  // Starts and ends one cycle step after the rising edge
  task automatic send(input bit may_block, output bit blocked);
    int waited;
    waited            = 0;
    trans_we_i        = rnd(2);
    trans_addr_i      = $random(seed);
    trans_be_i        = trans_we_i ? 4'(rnd(15) + 1) : 4'hf;
    trans_wdata_i     = $random(seed);
    trans_integrity_i = rnd(2);
    trans_valid_i     = 1'b1;
    @(negedge clk);
    while (!trans_ready_o && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    blocked = !trans_ready_o;
    if (blocked && !may_block) begin
      errors++;
      $display("Timeout: trans_ready_o never rose for a transaction");
    end
    @(posedge clk);
    #1;
    if (!blocked && rnd(4) == 0) begin
      trans_valid_i = 1'b0;
      repeat (rnd(3) + 1) @(posedge clk);
      #1;
    end
  endtask

  task automatic traffic(input int n, input bit may_block);
    bit blocked;
    for (int i = 0; i < n; i++) begin
      send(may_block, blocked);
      if (blocked) begin
        break;
      end
    end
    trans_valid_i = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(posedge clk);
    while ((q_at.size() != 0 || rsp_active) && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (q_at.size() != 0 || rsp_active) begin
      errors++;
      $display("Timeout: outstanding responses did not return");
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  // After the halt a held request must stay blocked
  task automatic expect_halt(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!halted_o && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!halted_o) begin
      errors++;
      $display("Timeout: %s did not halt after the integrity error", name);
    end
    check({name, " fault used"}, 0, {knob_gnt, knob_rvp, knob_flip});
    @(posedge clk);
    #1;
    trans_valid_i = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check({name, " trans_ready_o"}, 0, trans_ready_o);
      check({name, " obi_req_o"}, 0, obi_req_o);
      check({name, " alert_major_o"}, 1, alert_major_o);
    end
    trans_valid_i = 1'b0;
  endtask

  task automatic fault_phase(input string name, input logic [4:0] flip, input bit on_we,
                             input bit gnt, input bit rvp);
    integrity_en_i = 1'b1;
    reset_dut();
    knob_flip    = flip;
    knob_flip_we = on_we;
    knob_gnt     = gnt;
    knob_rvp     = rvp;
    traffic(30, 1'b1);
    expect_halt(name);
  endtask

  initial begin
    seed              = 32'hd369_4711;
    errors            = 0;
    rst_n             = 1'b0;
    trans_valid_i     = 1'b0;
    trans_addr_i      = '0;
    trans_we_i        = 1'b0;
    trans_be_i        = '0;
    trans_wdata_i     = '0;
    trans_integrity_i = 1'b0;
    integrity_en_i    = 1'b1;
    obi_gnt_i         = 1'b0;
    obi_gntpar_i      = 1'b1;
    obi_rvalid_i      = 1'b0;
    obi_rvalidpar_i   = 1'b1;
    obi_rdata_i       = '0;
    obi_err_i         = 1'b0;
    obi_rchk_i        = '0;
    knob_gnt          = 1'b0;
    knob_rvp          = 1'b0;
    knob_flip         = '0;
    knob_flip_we      = 1'b0;
    // Word pattern spread over the whole index
    for (int i = 0; i < 16; i++) begin
      mem[i] = (32'h9e37_79b9 * (i + 1)) ^ {4{i[7:0]}};
    end

    // Clean random traffic
    reset_dut();
    traffic(80, 1'b0);
    drain();
    check("clean alert_major_o", 0, alert_major_o);
    check("clean halted_o", 0, halted_o);

    // rchk bit 0 on a store is ignored
    reset_dut();
    knob_flip    = 5'h01;
    knob_flip_we = 1'b1;
    traffic(20, 1'b0);
    drain();
    check("store rchk0 used", 0, knob_flip);
    check("store rchk0 alert", 0, alert_major_o);

    fault_phase("gntpar", 5'h00, 1'b0, 1'b1, 1'b0);
    fault_phase("load rchk0", 5'h01, 1'b0, 1'b0, 1'b0);
    fault_phase("store rchk4", 5'h10, 1'b1, 1'b0, 1'b0);
    fault_phase("load rchk4", 5'h10, 1'b0, 1'b0, 1'b0);
    fault_phase("rvalidpar", 5'h00, 1'b0, 1'b0, 1'b1);

    // With checking off a corrupted rchk passes
    integrity_en_i = 1'b0;
    reset_dut();
    knob_flip    = 5'h01;
    knob_flip_we = 1'b0;
    traffic(20, 1'b0);
    drain();
    check("disabled load rchk0 used", 0, knob_flip);
    knob_flip    = 5'h10;
    knob_flip_we = 1'b1;
    traffic(20, 1'b0);
    drain();
    check("disabled rchk used", 0, knob_flip);
    check("disabled alert_major_o", 0, alert_major_o);
    check("disabled halted_o", 0, halted_o);

    $display("Checks done with %0d errors and %0d assertion failures", errors,
             obi_data_integ_top_i.integ_assertions_i.fails);
    if (errors == 0 && obi_data_integ_top_i.integ_assertions_i.fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
